// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       := lsu_tb
FILELIST  := list.f
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_mem_req_if.sv
logic/lsu_req_format.sv
logic/lsu_pending_table.sv
logic/lsu_rsp_format.sv
logic/lsu_commit_buffer.sv
logic/lsu_commit_arb.sv
logic/lsu_unit.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

// ==== logic/lsu_commit_arb.sv ====
// round-robin merge of load and store commits into one registered port

`include "lsu_macros.svh"

module lsu_commit_arb import lsu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          ld_valid,
    input  load_commit_t  ld_data,
    output logic          ld_ready,
    input  logic          st_valid,
    input  store_commit_t st_data,
    output logic          st_ready,
    output logic          out_valid,
    output commit_t       out_data,
    input  logic          out_ready
);

    logic prio_st;
    logic out_load;
    logic ld_fire;
    logic st_fire;

    assign out_load = out_ready || !out_valid;

    // the stream without priority yields only when the other is valid
    assign ld_ready = out_load && !(st_valid && prio_st);
    assign st_ready = out_load && !(ld_valid && !prio_st);

    assign ld_fire = ld_valid && ld_ready;
    assign st_fire = st_valid && st_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            prio_st   <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid <= ld_fire || st_fire;
            end
            if (ld_fire) begin
                prio_st <= 1'b1;
            end else if (st_fire) begin
                prio_st <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            out_data.wid   <= ld_data.wid;
            out_data.tmask <= ld_data.tmask;
            out_data.rd    <= ld_data.rd;
            out_data.wb    <= 1'b1;
            out_data.data  <= ld_data.data;
        end else if (st_fire) begin
            out_data.wid   <= st_data.wid;
            out_data.tmask <= st_data.tmask;
            out_data.rd    <= '0;
            out_data.wb    <= 1'b0;
            out_data.data  <= '0;
        end
    end

endmodule

// ==== logic/lsu_commit_buffer.sv ====
// two-entry elastic buffer, registered output plus skid entry

module lsu_commit_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     skid_valid;
    payload_t skid_data;
    logic     out_load;

    // output register free or draining this cycle
    assign out_load = out_ready || !out_valid;
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== logic/lsu_macros.svh ====
// lane count, data width, load queue depth and index widths
// for the load/store stage

`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// lanes and word geometry
`define LSU_NUM_LANES   4
`define LSU_XLEN        32
`define LSU_WORD_BYTES  4
`define LSU_ALIGN_BITS  2
`define LSU_WADDR_BITS  (`LSU_XLEN - `LSU_ALIGN_BITS)

// pending loads, one tag per slot
`define LSU_QUEUE_SIZE  4
`define LSU_TAG_BITS    2

// warp id and destination register
`define LSU_NW_BITS     2
`define LSU_NR_BITS     5

`endif

// ==== logic/lsu_mem_req_if.sv ====
// memory request bundle between request formatter and top level

`include "lsu_macros.svh"

interface lsu_mem_req_if import lsu_pkg::*; ();

    logic                              valid;
    logic                              rw;
    lane_mask_t                        mask;
    lane_waddr_t  [`LSU_NUM_LANES-1:0] addr;
    lane_byteen_t [`LSU_NUM_LANES-1:0] byteen;
    lane_data_t   [`LSU_NUM_LANES-1:0] data;
    logic                              ready;

    modport source (output valid, rw, mask, addr, byteen, data, input ready);

    modport sink (input valid, rw, mask, addr, byteen, data, output ready);

endinterface

// ==== logic/lsu_pending_table.sv ====
// outstanding load table: slot allocation, metadata store,
// lookup and release by response tag

`include "lsu_macros.svh"

module lsu_pending_table import lsu_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alloc,
    input  load_meta_t               alloc_meta,
    input  logic                     rsp_fire,
    input  logic [`LSU_TAG_BITS-1:0] rsp_tag,
    output logic [`LSU_TAG_BITS-1:0] free_tag,
    output logic                     slot_free,
    output logic                     table_empty,
    output load_meta_t               rsp_meta
);

    logic [`LSU_QUEUE_SIZE-1:0] busy;
    load_meta_t                 meta_q [`LSU_QUEUE_SIZE];

    // lowest free slot wins
    always_comb begin
        free_tag = '0;
        for (int i = `LSU_QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_tag = `LSU_TAG_BITS'(i);
            end
        end
    end

    assign slot_free   = ~&busy;
    assign table_empty = ~|busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            // alloc and release never hit the same slot
            if (alloc) begin
                busy[free_tag] <= 1'b1;
            end
            if (rsp_fire) begin
                busy[rsp_tag] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            meta_q[free_tag] <= alloc_meta;
        end
    end

    assign rsp_meta = meta_q[rsp_tag];

endmodule

// ==== logic/lsu_pkg.sv ====
// op codes, lane types, load metadata and commit payload structs

`include "lsu_macros.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_LB    = 4'd0,
        OP_LH    = 4'd1,
        OP_LW    = 4'd2,
        OP_LBU   = 4'd3,
        OP_LHU   = 4'd4,
        OP_SB    = 4'd5,
        OP_SH    = 4'd6,
        OP_SW    = 4'd7,
        OP_FENCE = 4'd8
    } lsu_op_e;

    typedef logic [`LSU_XLEN-1:0]       lane_data_t;
    typedef logic [`LSU_WADDR_BITS-1:0] lane_waddr_t;
    typedef logic [`LSU_WORD_BYTES-1:0] lane_byteen_t;
    typedef logic [`LSU_NUM_LANES-1:0]  lane_mask_t;
    typedef logic [`LSU_NUM_LANES-1:0][`LSU_ALIGN_BITS-1:0] lane_align_t;

    // kept per outstanding load, indexed by tag
    typedef struct packed {
        logic [`LSU_NW_BITS-1:0] wid;
        lane_mask_t              tmask;
        logic [`LSU_NR_BITS-1:0] rd;
        lsu_op_e                 op;
        lane_align_t             align;
    } load_meta_t;

    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]         wid;
        lane_mask_t                      tmask;
        logic [`LSU_NR_BITS-1:0]         rd;
        lane_data_t [`LSU_NUM_LANES-1:0] data;
    } load_commit_t;

    // stores and fences, nothing written back
    typedef struct packed {
        logic [`LSU_NW_BITS-1:0] wid;
        lane_mask_t              tmask;
    } store_commit_t;

    typedef struct packed {
        logic [`LSU_NW_BITS-1:0]         wid;
        lane_mask_t                      tmask;
        logic [`LSU_NR_BITS-1:0]         rd;
        logic                            wb;
        lane_data_t [`LSU_NUM_LANES-1:0] data;
    } commit_t;

endpackage

// ==== logic/lsu_req_format.sv ====
// lane address generation, byte enables, store data alignment
// and dispatch acceptance for loads, stores and fences

`include "lsu_macros.svh"

module lsu_req_format import lsu_pkg::*; (
    input  logic                            disp_valid,
    input  lsu_op_e                         disp_op,
    input  lane_mask_t                      disp_tmask,
    input  lane_data_t [`LSU_NUM_LANES-1:0] disp_base,
    input  lane_data_t [`LSU_NUM_LANES-1:0] disp_data,
    input  lane_data_t                      disp_imm,
    input  logic                            slot_free,
    input  logic                            table_empty,
    input  logic                            st_ready,
    output logic                            disp_ready,
    output lane_align_t                     align,
    lsu_mem_req_if.source                   req
);

    logic is_fence;
    logic is_store;
    logic path_open;

    assign is_fence = (disp_op == OP_FENCE);
    assign is_store = (disp_op == OP_SB) || (disp_op == OP_SH) || (disp_op == OP_SW);

    // stores need room for their commit, loads need a free tag
    assign path_open = is_store ? st_ready : slot_free;

    // fences never reach memory
    assign req.valid = disp_valid && !is_fence && path_open;
    assign req.rw    = is_store;
    assign req.mask  = disp_tmask;

    always_comb begin
        if (is_fence) begin
            // wait for all loads to drain
            disp_ready = table_empty && st_ready;
        end else begin
            disp_ready = req.ready && path_open;
        end
    end

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        lane_data_t   full_addr;
        lane_byteen_t be;

        assign full_addr = disp_base[i] + disp_imm;
        assign align[i]  = full_addr[`LSU_ALIGN_BITS-1:0];

        assign req.addr[i] = full_addr[`LSU_XLEN-1:`LSU_ALIGN_BITS];
        assign req.data[i] = disp_data[i] << {align[i], 3'b000};

        always_comb begin
            case (disp_op)
                OP_LB, OP_LBU, OP_SB: be = `LSU_WORD_BYTES'(1) << align[i];
                // half words sit on an even byte
                OP_LH, OP_LHU, OP_SH: be = `LSU_WORD_BYTES'(3) << {align[i][1], 1'b0};
                default:              be = '1;
            endcase
        end

        assign req.byteen[i] = be;
    end

endmodule

// ==== logic/lsu_rsp_format.sv ====
// load response formatting: byte or half select, sign or zero extension

`include "lsu_macros.svh"

module lsu_rsp_format import lsu_pkg::*; (
    input  load_meta_t                      rsp_meta,
    input  lane_data_t [`LSU_NUM_LANES-1:0] mem_rsp_data,
    output load_commit_t                    ld_payload
);

    function automatic lane_data_t extend_load(
        input lsu_op_e                   op,
        input lane_data_t                word,
        input logic [`LSU_ALIGN_BITS-1:0] off
    );
        logic [15:0] half;
        logic [7:0]  b8;
        half = off[1] ? word[31:16] : word[15:0];
        b8   = off[0] ? half[15:8] : half[7:0];
        case (op)
            OP_LB:   return {{(`LSU_XLEN-8){b8[7]}}, b8};
            OP_LH:   return {{(`LSU_XLEN-16){half[15]}}, half};
            OP_LBU:  return {{(`LSU_XLEN-8){1'b0}}, b8};
            OP_LHU:  return {{(`LSU_XLEN-16){1'b0}}, half};
            default: return word;
        endcase
    endfunction

    lane_data_t [`LSU_NUM_LANES-1:0] lane_data;

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        assign lane_data[i] = extend_load(rsp_meta.op, mem_rsp_data[i], rsp_meta.align[i]);
    end

    assign ld_payload.wid   = rsp_meta.wid;
    assign ld_payload.tmask = rsp_meta.tmask;
    assign ld_payload.rd    = rsp_meta.rd;
    assign ld_payload.data  = lane_data;

endmodule

// ==== logic/lsu_unit.sv ====
// load/store stage top: request formatting, pending load table,
// response formatting, commit buffers and commit arbiter

`include "lsu_macros.svh"

module lsu_unit import lsu_pkg::*; (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              disp_valid,
    output logic                              disp_ready,
    input  lsu_op_e                           disp_op,
    input  logic [`LSU_NW_BITS-1:0]           disp_wid,
    input  lane_mask_t                        disp_tmask,
    input  logic [`LSU_NR_BITS-1:0]           disp_rd,
    input  lane_data_t   [`LSU_NUM_LANES-1:0] disp_base,
    input  lane_data_t   [`LSU_NUM_LANES-1:0] disp_data,
    input  lane_data_t                        disp_imm,

    output logic                              mem_req_valid,
    output logic                              mem_req_rw,
    output lane_mask_t                        mem_req_mask,
    output lane_waddr_t  [`LSU_NUM_LANES-1:0] mem_req_addr,
    output lane_byteen_t [`LSU_NUM_LANES-1:0] mem_req_byteen,
    output lane_data_t   [`LSU_NUM_LANES-1:0] mem_req_data,
    output logic [`LSU_TAG_BITS-1:0]          mem_req_tag,
    input  logic                              mem_req_ready,

    input  logic                              mem_rsp_valid,
    input  lane_data_t   [`LSU_NUM_LANES-1:0] mem_rsp_data,
    input  logic [`LSU_TAG_BITS-1:0]          mem_rsp_tag,
    output logic                              mem_rsp_ready,

    output logic                              commit_valid,
    output logic [`LSU_NW_BITS-1:0]           commit_wid,
    output lane_mask_t                        commit_tmask,
    output logic [`LSU_NR_BITS-1:0]           commit_rd,
    output logic                              commit_wb,
    output lane_data_t   [`LSU_NUM_LANES-1:0] commit_data,
    input  logic                              commit_ready
);

    lsu_mem_req_if req_if ();

    lane_align_t   req_align;
    logic          slot_free;
    logic          table_empty;
    logic [`LSU_TAG_BITS-1:0] free_tag;
    load_meta_t    alloc_meta;
    load_meta_t    rsp_meta;
    load_commit_t  ld_payload;
    store_commit_t st_payload;
    logic          load_fire;
    logic          st_push;
    logic          st_in_ready;
    logic          ld_out_valid;
    logic          ld_out_ready;
    load_commit_t  ld_out_data;
    logic          st_out_valid;
    logic          st_out_ready;
    store_commit_t st_out_data;
    commit_t       arb_data;

    lsu_req_format u_req_format (
        .disp_valid  (disp_valid),
        .disp_op     (disp_op),
        .disp_tmask  (disp_tmask),
        .disp_base   (disp_base),
        .disp_data   (disp_data),
        .disp_imm    (disp_imm),
        .slot_free   (slot_free),
        .table_empty (table_empty),
        .st_ready    (st_in_ready),
        .disp_ready  (disp_ready),
        .align       (req_align),
        .req         (req_if.source)
    );

    // request bundle out to the memory ports
    assign mem_req_valid  = req_if.valid;
    assign mem_req_rw     = req_if.rw;
    assign mem_req_mask   = req_if.mask;
    assign mem_req_addr   = req_if.addr;
    assign mem_req_byteen = req_if.byteen;
    assign mem_req_data   = req_if.data;
    assign mem_req_tag    = free_tag;
    assign req_if.ready   = mem_req_ready;

    // anything accepted that is not a load commits from the request
    assign load_fire = req_if.valid && req_if.ready && !req_if.rw;
    assign st_push   = disp_valid && disp_ready && !load_fire;

    assign alloc_meta = '{wid: disp_wid, tmask: disp_tmask, rd: disp_rd,
                          op: disp_op, align: req_align};
    assign st_payload = '{wid: disp_wid, tmask: disp_tmask};

    lsu_pending_table u_pending_table (
        .clk         (clk),
        .reset       (reset),
        .alloc       (load_fire),
        .alloc_meta  (alloc_meta),
        .rsp_fire    (mem_rsp_valid && mem_rsp_ready),
        .rsp_tag     (mem_rsp_tag),
        .free_tag    (free_tag),
        .slot_free   (slot_free),
        .table_empty (table_empty),
        .rsp_meta    (rsp_meta)
    );

    lsu_rsp_format u_rsp_format (
        .rsp_meta     (rsp_meta),
        .mem_rsp_data (mem_rsp_data),
        .ld_payload   (ld_payload)
    );

    lsu_commit_buffer #(
        .payload_t (load_commit_t)
    ) u_ld_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mem_rsp_valid),
        .in_data   (ld_payload),
        .in_ready  (mem_rsp_ready),
        .out_valid (ld_out_valid),
        .out_data  (ld_out_data),
        .out_ready (ld_out_ready)
    );

    lsu_commit_buffer #(
        .payload_t (store_commit_t)
    ) u_st_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (st_push),
        .in_data   (st_payload),
        .in_ready  (st_in_ready),
        .out_valid (st_out_valid),
        .out_data  (st_out_data),
        .out_ready (st_out_ready)
    );

    lsu_commit_arb u_commit_arb (
        .clk       (clk),
        .reset     (reset),
        .ld_valid  (ld_out_valid),
        .ld_data   (ld_out_data),
        .ld_ready  (ld_out_ready),
        .st_valid  (st_out_valid),
        .st_data   (st_out_data),
        .st_ready  (st_out_ready),
        .out_valid (commit_valid),
        .out_data  (arb_data),
        .out_ready (commit_ready)
    );

    assign commit_wid   = arb_data.wid;
    assign commit_tmask = arb_data.tmask;
    assign commit_rd    = arb_data.rd;
    assign commit_wb    = arb_data.wb;
    assign commit_data  = arb_data.data;

endmodule

// ==== verification/lsu_checker.sv ====
// concurrent assertions on store request format, commit stability,
// store commit payload and reset behavior of the load/store stage

`include "lsu_macros.svh"

module lsu_checker import lsu_pkg::*; (
    input logic                              clk,
    input logic                              reset,
    input logic                              disp_valid,
    input lsu_op_e                           disp_op,
    input lane_mask_t                        disp_tmask,
    input lane_data_t   [`LSU_NUM_LANES-1:0] disp_base,
    input lane_data_t   [`LSU_NUM_LANES-1:0] disp_data,
    input lane_data_t                        disp_imm,
    input logic                              mem_req_valid,
    input logic                              mem_req_rw,
    input lane_mask_t                        mem_req_mask,
    input lane_waddr_t  [`LSU_NUM_LANES-1:0] mem_req_addr,
    input lane_byteen_t [`LSU_NUM_LANES-1:0] mem_req_byteen,
    input lane_data_t   [`LSU_NUM_LANES-1:0] mem_req_data,
    input logic                              commit_valid,
    input logic                              commit_ready,
    input logic [`LSU_NW_BITS-1:0]           commit_wid,
    input lane_mask_t                        commit_tmask,
    input logic [`LSU_NR_BITS-1:0]           commit_rd,
    input logic                              commit_wb,
    input lane_data_t   [`LSU_NUM_LANES-1:0] commit_data
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // byte lanes touched by a store of the given size
    function automatic logic [3:0] store_bytes(lsu_op_e op, logic [1:0] off);
        case (op)
            OP_SB:   return 4'b0001 << off;
            OP_SH:   return off[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        lane_data_t sum;

        assign sum = disp_base[i] + disp_imm;

        store_fmt_a: assert property (@(posedge clk) disable iff (reset)
            (mem_req_valid && mem_req_rw) |->
                (mem_req_addr[i] == sum[31:2]) && (mem_req_mask == disp_tmask) &&
                (mem_req_byteen[i] == store_bytes(disp_op, sum[1:0])) &&
                (mem_req_data[i] == (disp_data[i] << (8 * sum[1:0]))))
            else begin
                fail_count++;
                $error("store request lane %0d badly formatted", i);
            end
    end

    commit_hold_a: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=>
            (commit_valid && $stable(commit_wid) && $stable(commit_tmask) &&
             $stable(commit_rd) && $stable(commit_wb) && $stable(commit_data)))
        else begin
            fail_count++;
            $error("commit changed while stalled");
        end

    store_commit_a: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_wb) |-> (commit_data == '0) && (commit_rd == '0))
        else begin
            fail_count++;
            $error("store commit carries data or rd");
        end

    // registers settle one edge after reset is seen
    reset_a: assert property (@(posedge clk)
        $past(reset) |-> (!commit_valid && !mem_req_valid))
        else begin
            fail_count++;
            $error("valid high during or right after reset");
        end

endmodule

bind lsu_unit lsu_checker chk_i (.*);

// ==== verification/lsu_tb.sv ====
// testbench for the load/store stage: random dispatch, out-of-order
// memory model, load scoreboard, store commit queue and counts

`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_OPS = 80;
    localparam int LIMIT   = 200;

    logic clk, reset;
    logic disp_valid, disp_ready;
    lsu_op_e disp_op;
    logic [`LSU_NW_BITS-1:0] disp_wid;
    lane_mask_t disp_tmask;
    logic [`LSU_NR_BITS-1:0] disp_rd;
    lane_data_t [`LSU_NUM_LANES-1:0] disp_base, disp_data, mem_rsp_data, commit_data;
    lane_data_t disp_imm;
    logic mem_req_valid, mem_req_rw, mem_req_ready;
    lane_mask_t mem_req_mask, commit_tmask;
    lane_waddr_t  [`LSU_NUM_LANES-1:0] mem_req_addr;
    lane_byteen_t [`LSU_NUM_LANES-1:0] mem_req_byteen;
    lane_data_t   [`LSU_NUM_LANES-1:0] mem_req_data;
    logic [`LSU_TAG_BITS-1:0] mem_req_tag, mem_rsp_tag;
    logic mem_rsp_valid, mem_rsp_ready;
    logic commit_valid, commit_ready, commit_wb;
    logic [`LSU_NW_BITS-1:0] commit_wid;
    logic [`LSU_NR_BITS-1:0] commit_rd;

    int seed = 32'h522ef2b1;
    int errors = 0, cycle = 0, accepted = 0, loads = 0, stores = 0, fences = 0;
    int issued = 0, answered = 0, ld_commits = 0, st_commits = 0;
    bit timed_out = 1'b0;
    // scoreboard keyed by {wid, rd}
    bit         exp_valid [128];
    lane_mask_t exp_tmask [128];
    lane_data_t exp_data  [128][`LSU_NUM_LANES];
    logic [5:0] st_q [$];
    // memory model, one entry per tag
    bit          pend_valid [`LSU_QUEUE_SIZE];
    int          pend_due   [`LSU_QUEUE_SIZE];
    lane_waddr_t pend_addr  [`LSU_QUEUE_SIZE][`LSU_NUM_LANES];

    lsu_unit dut_i (.*);

    function automatic lane_data_t mem_word(lane_waddr_t waddr, int lane);
        return ({2'b00, waddr} ^ 32'h5a5a_0000) + lane;
    endfunction

    function automatic lane_data_t load_value(lsu_op_e op, lane_data_t word, logic [1:0] off);
        lane_data_t sh;
        sh = word >> (8 * off);
        case (op)
            OP_LB:   return {{24{sh[7]}}, sh[7:0]};
            OP_LBU:  return {24'h0, sh[7:0]};
            OP_LH:   return {{16{sh[15]}}, sh[15:0]};
            OP_LHU:  return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory side: requests, delayed replies, random back-pressure
    always begin
        int start, t;
        @(posedge clk);
        cycle++;
        if (!reset) begin
            if (disp_valid && disp_ready && disp_op == OP_FENCE) begin
                assert (issued == answered) else begin
                    errors++;
                    $display("fence accepted at %0t with %0d loads unanswered",
                             $time, issued - answered);
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                pend_valid[mem_rsp_tag] = 1'b0;
                answered++;
            end
            if (mem_req_valid && mem_req_ready && !mem_req_rw) begin
                pend_valid[mem_req_tag] = 1'b1;
                pend_due[mem_req_tag]   = cycle + 1 + {$random(seed)} % 8;
                for (int l = 0; l < `LSU_NUM_LANES; l++) begin
                    pend_addr[mem_req_tag][l] = mem_req_addr[l];
                end
                issued++;
            end
        end
        #1;
        mem_req_ready = ({$random(seed)} % 4) != 0;
        commit_ready  = ({$random(seed)} % 4) != 0;
        // a reply is withdrawn only once it has transferred
        if (mem_rsp_valid && !pend_valid[mem_rsp_tag]) begin
            mem_rsp_valid = 1'b0;
        end
        if (!mem_rsp_valid && !reset) begin
            start = {$random(seed)} % `LSU_QUEUE_SIZE;
            for (int k = 0; k < `LSU_QUEUE_SIZE; k++) begin
                t = (start + k) % `LSU_QUEUE_SIZE;
                if (!mem_rsp_valid && pend_valid[t] && pend_due[t] <= cycle) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_tag   = `LSU_TAG_BITS'(t);
                    for (int l = 0; l < `LSU_NUM_LANES; l++) begin
                        mem_rsp_data[l] = mem_word(pend_addr[t][l], l);
                    end
                end
            end
        end
    end

    // commit monitor
    always @(posedge clk) begin
        logic [6:0] key;
        logic [5:0] st_exp;
        if (!reset && commit_valid && commit_ready) begin
            key = {commit_wid, commit_rd};
            if (commit_wb) begin
                ld_commits++;
                assert (exp_valid[key]) else begin
                    errors++;
                    $display("load commit at %0t for wid %0d rd %0d with no load pending",
                             $time, commit_wid, commit_rd);
                end
                assert (commit_tmask == exp_tmask[key]) else begin
                    errors++;
                    $display("MISMATCH %0t commit_tmask got %h exp %h",
                             $time, commit_tmask, exp_tmask[key]);
                end
                for (int l = 0; l < `LSU_NUM_LANES; l++) begin
                    if (commit_tmask[l]) begin
                        assert (commit_data[l] == exp_data[key][l]) else begin
                            errors++;
                            $display("MISMATCH %0t commit_data[%0d] got %h exp %h",
                                     $time, l, commit_data[l], exp_data[key][l]);
                        end
                    end
                end
                exp_valid[key] = 1'b0;
            end else begin
                st_commits++;
                assert (st_q.size() != 0) else begin
                    errors++;
                    $display("store commit at %0t with nothing accepted", $time);
                end
                if (st_q.size() != 0) begin
                    st_exp = st_q.pop_front();
                    assert ({commit_wid, commit_tmask} == st_exp) else begin
                        errors++;
                        $display("MISMATCH %0t commit_wid/tmask got %h exp %h",
                                 $time, {commit_wid, commit_tmask}, st_exp);
                    end
                end
            end
        end
    end

    initial begin
        int op_i, cnt;
        lane_data_t a;
        disp_valid = 1'b0;
        disp_op = OP_LW;
        disp_wid = '0;
        disp_tmask = '0;
        disp_rd = '0;
        disp_base = '0;
        disp_data = '0;
        disp_imm = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        mem_rsp_tag = '0;
        commit_ready = 1'b0;
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        repeat (2) @(posedge clk);
        for (int n = 0; n < NUM_OPS && !timed_out; n++) begin
            #1;
            op_i = {$random(seed)} % 10;
            disp_op = (op_i == 9) ? OP_LW : lsu_op_e'(op_i);
            disp_wid = `LSU_NW_BITS'($random(seed));
            disp_tmask = `LSU_NUM_LANES'($random(seed));
            disp_imm = $random(seed);
            do disp_rd = `LSU_NR_BITS'($random(seed)); while (exp_valid[{disp_wid, disp_rd}]);
            for (int l = 0; l < `LSU_NUM_LANES; l++) begin
                a = $random(seed);
                if (disp_op inside {OP_LH, OP_LHU, OP_SH}) a[0] = 1'b0;
                if (disp_op inside {OP_LW, OP_SW}) a[1:0] = 2'b00;
                disp_base[l] = a - disp_imm;
                disp_data[l] = $random(seed);
                exp_data[{disp_wid, disp_rd}][l] =
                    load_value(disp_op, mem_word(a[31:2], l), a[1:0]);
            end
            disp_valid = 1'b1;
            cnt = 0;
            do begin
                @(posedge clk);
                cnt++;
            end while (!disp_ready && cnt < LIMIT);
            if (!disp_ready) begin
                timed_out = 1'b1;
                $display("timeout at %0t while waiting for dispatch ready", $time);
            end else begin
                accepted++;
                if (disp_op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU}) begin
                    loads++;
                    exp_valid[{disp_wid, disp_rd}] = 1'b1;
                    exp_tmask[{disp_wid, disp_rd}] = disp_tmask;
                end else begin
                    if (disp_op == OP_FENCE) fences++;
                    else stores++;
                    st_q.push_back({disp_wid, disp_tmask});
                end
            end
        end
        #1 disp_valid = 1'b0;
        cnt = 0;
        while (!timed_out && ld_commits + st_commits < accepted && cnt < 10 * LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (!timed_out && ld_commits + st_commits < accepted) begin
            timed_out = 1'b1;
            $display("timeout at %0t while waiting for final commits", $time);
        end
        repeat (4) @(posedge clk);
        assert (ld_commits == loads) else begin
            errors++;
            $display("MISMATCH %0t load commits got %0d exp %0d", $time, ld_commits, loads);
        end
        assert (st_commits == stores + fences) else begin
            errors++;
            $display("MISMATCH %0t store commits got %0d exp %0d",
                     $time, st_commits, stores + fences);
        end
        $display("loads %0d stores %0d fences %0d commits %0d errors %0d assertion errors %0d",
                 loads, stores, fences, ld_commits + st_commits, errors, dut_i.chk_i.fail_count);
        if (!timed_out && errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
